/* rtl/ts_consts.svh */
`ifndef TS_CONSTS_SVH
`define TS_CONSTS_SVH

// sprite file geometry
`define TS_SFILE_DEPTH 256
`define TS_SFILE_AW 8
`define TS_DATA_W 16

// apb byte offsets
`define TS_REG_CTRL 12'h000
`define TS_REG_SGPAGE 12'h004
// sprite file window, one 16-bit entry per 32-bit word
`define TS_SFILE_BASE 12'h400

// three sprite layers, each closed by a leap sprite
`define TS_NUM_LAYERS 3

`endif

/* rtl/ts_sprite_pkg.sv */
`default_nettype none

package ts_sprite_pkg;

	// scanner states, one sprite walked per pass R0_RD..ISSUE
	typedef enum logic [2:0]
	{
		IDLE,
		R0_RD,
		R0_EVAL,
		R1_RD,
		R1_LATCH,
		R2_RD,
		ISSUE,
		DONE
	} scan_state_t;

	// video line or bitmap line, 512 lines
	typedef logic [8:0] ts_line_t;

	// layer number 0..2
	typedef logic [1:0] spr_layer_t;

	// renderer task fields
	typedef logic [8:0] spr_x_t;
	// x size in 8 pixel steps
	typedef logic [2:0] spr_size_t;
	// graphics word within the line
	typedef logic [5:0] spr_addr_t;
	typedef logic [3:0] spr_pal_t;
	typedef logic [7:0] spr_page_t;
	// line offset inside a sprite, up to 64 lines
	typedef logic [5:0] spr_ofs_t;

endpackage

`default_nettype wire

/* rtl/ts_apb_pkg.sv */
`default_nettype none

package ts_apb_pkg;

	// apb data bus
	typedef logic [31:0] apb_data_t;

	// decoded register target
	typedef enum logic [1:0]
	{
		REG_CTRL,
		REG_SGPAGE,
		REG_SFILE,
		REG_NONE
	} apb_reg_t;

endpackage

`default_nettype wire

/* rtl/ts_apb_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ts_consts.svh"

module ts_apb_regs (
	input wire clk,
	input wire arst_n,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire logic [11:0] paddr,
	input wire ts_apb_pkg::apb_data_t pwdata,
	output ts_apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic s_en,
	output logic [7:0] sgpage,
	output logic sfile_we,
	output logic [`TS_SFILE_AW-1:0] sfile_waddr,
	output logic [`TS_DATA_W-1:0] sfile_wdata
);
	import ts_apb_pkg::*;

	// low address bits covered by the file window
	localparam logic [11:0] SFILE_MASK = 12'(`TS_SFILE_DEPTH * 4 - 1);

	apb_reg_t reg_sel;
	logic wr_acc;
	logic rd_acc;

	// address decode
	always_comb
	begin
		if (paddr == `TS_REG_CTRL)
			reg_sel = REG_CTRL;
		else if (paddr == `TS_REG_SGPAGE)
			reg_sel = REG_SGPAGE;
		else if ((paddr & ~SFILE_MASK) == `TS_SFILE_BASE)
			reg_sel = REG_SFILE;
		else
			reg_sel = REG_NONE;
	end

	// access phase, no wait states
	assign wr_acc = psel && penable && pwrite;
	assign rd_acc = psel && penable && !pwrite;
	assign pready = 1'b1;

	// config registers and file write strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s_en <= 1'b0;
			sgpage <= '0;
			sfile_we <= 1'b0;
		end
		else
		begin
			if (wr_acc && reg_sel == REG_CTRL)
				s_en <= pwdata[0];
			if (wr_acc && reg_sel == REG_SGPAGE)
				sgpage <= pwdata[7:0];
			// one pulse per access phase
			sfile_we <= wr_acc && reg_sel == REG_SFILE;
		end
	end

	// word index and low half of the bus
	always_ff @(posedge clk)
	begin
		sfile_waddr <= paddr[`TS_SFILE_AW+1:2];
		sfile_wdata <= pwdata[`TS_DATA_W-1:0];
	end

	// readback, file window is write only
	always_comb
	begin
		prdata = '0;
		pslverr = 1'b0;
		case (reg_sel)
			REG_CTRL: prdata[0] = s_en;
			REG_SGPAGE: prdata[7:0] = sgpage;
			REG_SFILE: pslverr = rd_acc;
			default: prdata = '0;
		endcase
	end

	// apb access phase is one cycle, so a file write never stretches
	a_we_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		sfile_we |=> !sfile_we);

endmodule

`default_nettype wire

/* rtl/ts_sprite_file.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ts_consts.svh"

module ts_sprite_file (
	input wire clk,
	input wire we,
	input wire logic [`TS_SFILE_AW-1:0] waddr,
	input wire logic [`TS_SFILE_AW-1:0] raddr,
	input wire logic [`TS_DATA_W-1:0] wdata,
	output logic [`TS_DATA_W-1:0] rdata
);

	// three words per sprite, entry 255 spare
	logic [`TS_DATA_W-1:0] mem [`TS_SFILE_DEPTH];

	// cpu side write port
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// scanner side, data one cycle after the address
	// same-address write returns the old word
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* rtl/ts_sprite_scan.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ts_consts.svh"

module ts_sprite_scan (
	input wire clk,
	input wire arst_n,
	input wire start,
	input wire ts_sprite_pkg::ts_line_t line,
	input wire s_en,
	input wire ts_sprite_pkg::spr_page_t sgpage,
	output logic [`TS_SFILE_AW-1:0] sfile_raddr,
	input wire logic [`TS_DATA_W-1:0] sfile_rdata,
	input wire tsr_rdy,
	output logic tsr_go,
	output ts_sprite_pkg::spr_x_t tsr_x,
	output ts_sprite_pkg::spr_size_t tsr_xs,
	output logic tsr_xf,
	output ts_sprite_pkg::ts_line_t tsr_line,
	output ts_sprite_pkg::spr_addr_t tsr_addr,
	output ts_sprite_pkg::spr_pal_t tsr_pal,
	output ts_sprite_pkg::spr_page_t tsr_page,
	output ts_sprite_pkg::spr_layer_t tsr_layer,
	output logic scan_busy,
	output logic scan_done
);
	import ts_sprite_pkg::*;

	// base of the last full sprite, 252
	localparam int LAST_BASE = (`TS_SFILE_DEPTH / 3 - 1) * 3;
	localparam int LAST_LAYER = `TS_NUM_LAYERS - 1;

	scan_state_t state;
	scan_state_t state_nxt;
	logic [`TS_SFILE_AW-1:0] base;
	spr_layer_t layer;
	spr_ofs_t ofs_r;
	logic leap_r;

	// R0 fields
	ts_line_t r0_ycrd;
	spr_size_t r0_ysz;
	logic r0_act;
	logic r0_leap;
	logic r0_yflp;
	// R2 fields
	logic [11:0] r2_tnum;

	ts_line_t spr_line;
	spr_ofs_t ymax;
	spr_ofs_t bm_ofs;
	logic spr_hit;
	logic last_spr;
	logic last_layer;
	logic spr_next;
	logic leap_step;

	assign r0_ycrd = sfile_rdata[8:0];
	assign r0_ysz = sfile_rdata[11:9];
	assign r0_act = sfile_rdata[13];
	assign r0_leap = sfile_rdata[14];
	assign r0_yflp = sfile_rdata[15];
	assign r2_tnum = sfile_rdata[11:0];

	// sprite y geometry, line wraps at 512
	assign spr_line = line - r0_ycrd;
	assign ymax = {r0_ysz, 3'b111};
	assign spr_hit = r0_act && (spr_line <= {3'b000, ymax});
	// bitmap row inside the sprite
	assign bm_ofs = r0_yflp ? (ymax - spr_line[5:0]) : spr_line[5:0];

	assign last_spr = int'(base) == LAST_BASE;
	assign last_layer = layer == spr_layer_t'(LAST_LAYER);

	// next state
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE, DONE:
			begin
				if (start)
					state_nxt = s_en ? R0_RD : DONE;
				else
					state_nxt = IDLE;
			end
			R0_RD: state_nxt = R0_EVAL;
			R0_EVAL:
			begin
				if (spr_hit)
					state_nxt = R1_RD;
				else if (last_spr || (r0_leap && last_layer))
					state_nxt = DONE;
				else
					state_nxt = R0_RD;
			end
			R1_RD: state_nxt = R1_LATCH;
			R1_LATCH: state_nxt = R2_RD;
			R2_RD: state_nxt = ISSUE;
			ISSUE:
			begin
				// hold here until the renderer takes the task
				if (tsr_rdy)
					state_nxt = (last_spr || (leap_r && last_layer)) ? DONE : R0_RD;
			end
			default: state_nxt = IDLE;
		endcase
	end

	// step to the next sprite after skip or issue
	assign spr_next = state_nxt == R0_RD && (state == R0_EVAL || state == ISSUE);
	// leap on a skipped sprite counts now, on a drawn one after its task
	assign leap_step = (state == R0_EVAL && !spr_hit && r0_leap) || (tsr_go && leap_r);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= IDLE;
			base <= '0;
			layer <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (start && !scan_busy)
			begin
				base <= '0;
				layer <= '0;
			end
			else
			begin
				if (spr_next)
					base <= base + 2'd3;
				if (leap_step)
					layer <= layer + 1'b1;
			end
		end
	end

	// per sprite payload
	always_ff @(posedge clk)
	begin
		if (state == R0_EVAL)
		begin
			ofs_r <= bm_ofs;
			leap_r <= r0_leap;
		end
		// R1 word
		if (state == R1_LATCH)
		begin
			tsr_x <= sfile_rdata[8:0];
			tsr_xs <= sfile_rdata[11:9];
			tsr_xf <= sfile_rdata[15];
		end
	end

	// R2 stays addressed through ISSUE so rdata holds while stalled
	always_comb
	begin
		case (state)
			R1_RD, R1_LATCH: sfile_raddr = base + 1'b1;
			R2_RD, ISSUE: sfile_raddr = base + 2'd2;
			default: sfile_raddr = base;
		endcase
	end

	// renderer task
	assign tsr_go = state == ISSUE && tsr_rdy;
	assign tsr_line = {r2_tnum[11:6], 3'b000} + ts_line_t'(ofs_r);
	assign tsr_addr = r2_tnum[5:0];
	assign tsr_pal = sfile_rdata[15:12];
	assign tsr_page = sgpage;
	assign tsr_layer = layer;

	assign scan_busy = state != IDLE && state != DONE;
	assign scan_done = state == DONE;

	// no task once the last layer has closed
	a_go_layer: assert property (@(posedge clk) disable iff (!arst_n)
		tsr_go |-> int'(tsr_layer) <= LAST_LAYER);

	// reads never run past the last sprite word
	a_raddr_range: assert property (@(posedge clk) disable iff (!arst_n)
		scan_busy |-> int'(sfile_raddr) <= LAST_BASE + 2);

endmodule

`default_nettype wire

/* rtl/ts_sprite_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ts_consts.svh"

module ts_sprite_top (
	input wire clk,
	input wire arst_n,
	// cpu bus
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire logic [11:0] paddr,
	input wire ts_apb_pkg::apb_data_t pwdata,
	output wire ts_apb_pkg::apb_data_t prdata,
	output wire pready,
	output wire pslverr,
	// video timing
	input wire start,
	input wire ts_sprite_pkg::ts_line_t line,
	// renderer
	output wire tsr_go,
	output wire ts_sprite_pkg::spr_x_t tsr_x,
	output wire ts_sprite_pkg::spr_size_t tsr_xs,
	output wire tsr_xf,
	output wire ts_sprite_pkg::ts_line_t tsr_line,
	output wire ts_sprite_pkg::spr_addr_t tsr_addr,
	output wire ts_sprite_pkg::spr_page_t tsr_page,
	output wire ts_sprite_pkg::spr_pal_t tsr_pal,
	output wire ts_sprite_pkg::spr_layer_t tsr_layer,
	input wire tsr_rdy,
	output wire scan_busy,
	output wire scan_done
);

	// config into the scanner
	wire s_en;
	wire [7:0] sgpage;
	// sprite file ports
	wire sfile_we;
	wire [`TS_SFILE_AW-1:0] sfile_waddr;
	wire [`TS_DATA_W-1:0] sfile_wdata;
	wire [`TS_SFILE_AW-1:0] sfile_raddr;
	wire [`TS_DATA_W-1:0] sfile_rdata;

	ts_apb_regs u_regs (
		.clk(clk),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.s_en(s_en),
		.sgpage(sgpage),
		.sfile_we(sfile_we),
		.sfile_waddr(sfile_waddr),
		.sfile_wdata(sfile_wdata)
	);

	ts_sprite_file u_sfile (
		.clk(clk),
		.we(sfile_we),
		.waddr(sfile_waddr),
		.raddr(sfile_raddr),
		.wdata(sfile_wdata),
		.rdata(sfile_rdata)
	);

	ts_sprite_scan u_scan (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.line(line),
		.s_en(s_en),
		.sgpage(sgpage),
		.sfile_raddr(sfile_raddr),
		.sfile_rdata(sfile_rdata),
		.tsr_rdy(tsr_rdy),
		.tsr_go(tsr_go),
		.tsr_x(tsr_x),
		.tsr_xs(tsr_xs),
		.tsr_xf(tsr_xf),
		.tsr_line(tsr_line),
		.tsr_addr(tsr_addr),
		.tsr_pal(tsr_pal),
		.tsr_page(tsr_page),
		.tsr_layer(tsr_layer),
		.scan_busy(scan_busy),
		.scan_done(scan_done)
	);

endmodule

`default_nettype wire

/* tb/ts_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ts_checker (
	input wire clk,
	input wire arst_n,
	input wire tsr_go,
	input wire ts_sprite_pkg::spr_x_t tsr_x,
	input wire ts_sprite_pkg::spr_size_t tsr_xs,
	input wire tsr_xf,
	input wire ts_sprite_pkg::ts_line_t tsr_line,
	input wire ts_sprite_pkg::spr_addr_t tsr_addr,
	input wire ts_sprite_pkg::spr_pal_t tsr_pal,
	input wire ts_sprite_pkg::spr_page_t tsr_page,
	input wire ts_sprite_pkg::spr_layer_t tsr_layer,
	input wire scan_busy,
	input wire scan_done
);
	import ts_sprite_pkg::*;

	// one renderer task as the golden file lists it
	typedef struct packed
	{
		spr_x_t x;
		spr_size_t xs;
		logic xf;
		ts_line_t line;
		spr_addr_t addr;
		spr_pal_t pal;
		spr_page_t page;
		spr_layer_t layer;
	} rtask_t;

	rtask_t exp_q [$];
	string test_name = "none";
	int errs = 0;
	// set once the scan of this test has ended
	logic done_seen = 1'b0;

	task automatic begin_test(input string name);
		test_name = name;
		errs = 0;
		done_seen = 1'b0;
		exp_q.delete();
	endtask

	task automatic expect_task(
		input logic [31:0] x,
		input logic [31:0] xs,
		input logic [31:0] xf,
		input logic [31:0] ln,
		input logic [31:0] addr,
		input logic [31:0] pal,
		input logic [31:0] page,
		input logic [31:0] layer
	);
		rtask_t t;
		t.x = x[8:0];
		t.xs = xs[2:0];
		t.xf = xf[0];
		t.line = ln[8:0];
		t.addr = addr[5:0];
		t.pal = pal[3:0];
		t.page = page[7:0];
		t.layer = layer[1:0];
		exp_q.push_back(t);
	endtask

	task automatic check_field(input string field, input int exp, input int act);
		if (exp != act)
		begin
			$display("error %s %s expected %0h actual %0h", test_name, field, exp, act);
			errs++;
		end
	endtask

	// tasks still queued were never issued
	function automatic int finish_test();
		if (exp_q.size() != 0)
		begin
			$display("test %s ended with %0d expected tasks never issued",
				test_name, exp_q.size());
			errs += exp_q.size();
		end
		return errs;
	endfunction

	// sample at the edge, fields are valid with tsr_go
	always @(posedge clk)
	begin
		rtask_t e;
		if (arst_n && tsr_go)
		begin
			if (done_seen || exp_q.size() == 0)
			begin
				$display("test %s got a task it did not expect, x %0h line %0h layer %0d",
					test_name, tsr_x, tsr_line, tsr_layer);
				errs++;
			end
			else
			begin
				e = exp_q.pop_front();
				check_field("x", int'(e.x), int'(tsr_x));
				check_field("xs", int'(e.xs), int'(tsr_xs));
				check_field("xf", int'(e.xf), int'(tsr_xf));
				check_field("line", int'(e.line), int'(tsr_line));
				check_field("addr", int'(e.addr), int'(tsr_addr));
				check_field("pal", int'(e.pal), int'(tsr_pal));
				check_field("page", int'(e.page), int'(tsr_page));
				check_field("layer", int'(e.layer), int'(tsr_layer));
			end
		end
		// busy covers every task and drops with scan_done
		if (arst_n && tsr_go && !scan_busy)
		begin
			$display("error %s scan_busy expected 1 actual 0", test_name);
			errs++;
		end
		if (arst_n && scan_done && scan_busy)
		begin
			$display("error %s scan_busy expected 0 actual 1", test_name);
			errs++;
		end
		if (arst_n && scan_done)
			done_seen = 1'b1;
	end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ts_consts.svh"

module tb_top;
	import ts_apb_pkg::*;
	import ts_sprite_pkg::*;

	// cycles allowed for one full scan with random ready
	localparam int SCAN_LIMIT = 4000;

	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic start;
	ts_line_t line;
	logic tsr_go;
	spr_x_t tsr_x;
	spr_size_t tsr_xs;
	logic tsr_xf;
	ts_line_t tsr_line;
	spr_addr_t tsr_addr;
	spr_page_t tsr_page;
	spr_pal_t tsr_pal;
	spr_layer_t tsr_layer;
	logic tsr_rdy = 1'b1;
	logic scan_busy;
	logic scan_done;

	logic rdy_rand = 1'b0;
	integer seed = 71;
	int rnd;
	int fd;
	int n_tests = 0;
	int n_pass = 0;
	// golden file trouble or a scan that never ended
	logic aborted = 1'b0;

	ts_sprite_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.start(start),
		.line(line),
		.tsr_go(tsr_go),
		.tsr_x(tsr_x),
		.tsr_xs(tsr_xs),
		.tsr_xf(tsr_xf),
		.tsr_line(tsr_line),
		.tsr_addr(tsr_addr),
		.tsr_page(tsr_page),
		.tsr_pal(tsr_pal),
		.tsr_layer(tsr_layer),
		.tsr_rdy(tsr_rdy),
		.scan_busy(scan_busy),
		.scan_done(scan_done)
	);

	ts_checker chk_i (
		.clk(clk),
		.arst_n(arst_n),
		.tsr_go(tsr_go),
		.tsr_x(tsr_x),
		.tsr_xs(tsr_xs),
		.tsr_xf(tsr_xf),
		.tsr_line(tsr_line),
		.tsr_addr(tsr_addr),
		.tsr_pal(tsr_pal),
		.tsr_page(tsr_page),
		.tsr_layer(tsr_layer),
		.scan_busy(scan_busy),
		.scan_done(scan_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// renderer model, ready held high or random per cycle
	always @(posedge clk)
	begin
		rnd = $random(seed);
		if (rdy_rand)
			tsr_rdy <= rnd[0];
		else
			tsr_rdy <= 1'b1;
	end

	// apb write, setup then access phase
	task automatic write_reg(input logic [11:0] addr, input apb_data_t data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic read_reg(input logic [11:0] addr, output apb_data_t data, output logic err,
		output logic ack);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		// read data mid access phase
		@(negedge clk);
		data = prdata;
		err = pslverr;
		ack = pready;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// zero words are inactive sprites without leap
	task automatic clear_file();
		for (int i = 0; i < `TS_SFILE_DEPTH; i++)
			write_reg(12'(`TS_SFILE_BASE + i * 4), '0);
	endtask

	// next golden line, comment and empty lines skipped
	task automatic next_line(output string text, output logic got);
		int n;
		got = 1'b0;
		while (!got && !$feof(fd))
		begin
			n = $fgets(text, fd);
			if (n > 1 && text[0] != "#")
				got = 1'b1;
		end
	endtask

	task automatic wait_done(output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < SCAN_LIMIT)
		begin
			@(negedge clk);
			cycles++;
			if (scan_done)
				ok = 1'b1;
		end
	endtask

	task automatic run_test(
		input string name,
		input logic [31:0] ctrl,
		input logic [31:0] page,
		input logic [31:0] ln,
		input logic [31:0] rdy,
		input logic [31:0] nspr,
		input logic [31:0] ntask
	);
		string text;
		string tag;
		logic got;
		logic ok;
		logic err;
		logic ack;
		apb_data_t rd;
		logic [31:0] w [4];
		logic [31:0] ex [8];
		int errs;
		errs = 0;
		clear_file();
		chk_i.begin_test(name);
		// sprite index then R0 R1 R2
		for (int i = 0; i < int'(nspr); i++)
		begin
			next_line(text, got);
			if (!got || $sscanf(text, "%s %h %h %h %h", tag, w[0], w[1], w[2], w[3]) != 5
				|| tag != "s")
			begin
				$display("golden file has a bad sprite line in test %s", name);
				aborted = 1'b1;
			end
			else
			begin
				for (int k = 0; k < 3; k++)
					write_reg(12'(`TS_SFILE_BASE + (int'(w[0]) * 3 + k) * 4), w[k + 1]);
			end
		end
		for (int i = 0; i < int'(ntask); i++)
		begin
			next_line(text, got);
			if (!got || $sscanf(text, "%s %h %h %h %h %h %h %h %h", tag, ex[0], ex[1],
				ex[2], ex[3], ex[4], ex[5], ex[6], ex[7]) != 9 || tag != "t")
			begin
				$display("golden file has a bad task line in test %s", name);
				aborted = 1'b1;
			end
			else
				chk_i.expect_task(ex[0], ex[1], ex[2], ex[3], ex[4], ex[5], ex[6], ex[7]);
		end
		write_reg(`TS_REG_SGPAGE, page);
		write_reg(`TS_REG_CTRL, ctrl);
		// register readback
		read_reg(`TS_REG_CTRL, rd, err, ack);
		if (rd != (ctrl & 32'h1))
		begin
			$display("error %s ctrl expected %0h actual %0h", name, ctrl & 32'h1, rd);
			errs++;
		end
		read_reg(`TS_REG_SGPAGE, rd, err, ack);
		if (rd != (page & 32'hff))
		begin
			$display("error %s sgpage expected %0h actual %0h", name, page & 32'hff, rd);
			errs++;
		end
		// file window is write only
		read_reg(`TS_SFILE_BASE, rd, err, ack);
		if (err !== 1'b1)
		begin
			$display("error %s pslverr expected 1 actual %b", name, err);
			errs++;
		end
		// no wait states on any transfer
		if (ack !== 1'b1)
		begin
			$display("error %s pready expected 1 actual %b", name, ack);
			errs++;
		end
		@(posedge clk);
		rdy_rand <= rdy[0];
		line <= ln[8:0];
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		wait_done(ok);
		rdy_rand = 1'b0;
		if (!ok)
		begin
			$display("timeout in test %s, scan_done did not arrive within %0d cycles",
				name, SCAN_LIMIT);
			aborted = 1'b1;
		end
		errs += chk_i.finish_test();
		n_tests++;
		if (errs == 0 && ok)
			n_pass++;
		$display("test %s: %s, %0d errors", name, (errs == 0 && ok) ? "pass" : "fail", errs);
	endtask

	initial
	begin
		string text;
		string kw;
		string name;
		logic got;
		logic [31:0] hdr [6];
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		start = 1'b0;
		line = '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		fd = $fopen("tb/ts_golden.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open tb/ts_golden.txt");
			aborted = 1'b1;
		end
		got = 1'b1;
		// name ctrl page line rdy sprites tasks
		while (fd != 0 && got && !aborted)
		begin
			next_line(text, got);
			if (got)
			begin
				if ($sscanf(text, "%s %s %h %h %h %h %h %h", kw, name, hdr[0], hdr[1],
					hdr[2], hdr[3], hdr[4], hdr[5]) != 8 || kw != "test")
				begin
					$display("golden file line not understood: %s", text);
					aborted = 1'b1;
				end
				else
					run_test(name, hdr[0], hdr[1], hdr[2], hdr[3], hdr[4], hdr[5]);
			end
		end
		$display("tests run %0d, passed %0d, failed %0d", n_tests, n_pass, n_tests - n_pass);
		if (!aborted && n_tests > 0 && n_pass == n_tests)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/ts_golden.txt */
# test name ctrl page line rdy_random sprites tasks, then per sprite: s index r0 r1 r2
# per expected task: t x xs xf line addr pal page layer, all numbers hex
test visibility 1 12 064 0 5 2
s 0 2028 0000 0000
s 1 2260 0220 3045
s 2 2665 0000 0000
s 3 0064 0000 0000
s 4 245a 8fff a0c3
t 020 1 0 00c 05 3 12 0
t 1ff 7 1 022 03 a 12 0
test geometry_flip 1 5a 003 0 3 3
s 0 a3fc 0005 f7ff
s 1 ae00 8700 5000
s 2 2002 04aa 1fc0
t 005 0 0 100 3f f 5a 0
t 100 3 1 03c 00 5 5a 0
t 0aa 2 0 1f9 00 1 5a 0
test layers 1 01 032 0 6 4
s 0 2030 0010 0001
s 1 6030 0011 0002
s 2 4030 0000 0000
s 3 2030 0013 0004
s 4 6030 0014 0005
s 5 2030 0015 0006
t 010 0 0 002 01 0 01 0
t 011 0 0 002 02 0 01 0
t 013 0 0 002 04 0 01 2
t 014 0 0 002 05 0 01 2
test backpressure 1 01 032 1 6 4
s 0 2030 0010 0001
s 1 6030 0011 0002
s 2 4030 0000 0000
s 3 2030 0013 0004
s 4 6030 0014 0005
s 5 2030 0015 0006
t 010 0 0 002 01 0 01 0
t 011 0 0 002 02 0 01 0
t 013 0 0 002 04 0 01 2
t 014 0 0 002 05 0 01 2
test disabled 0 33 032 0 1 0
s 0 2030 0010 0001

/* sources.f */
+incdir+rtl
rtl/ts_sprite_pkg.sv
rtl/ts_apb_pkg.sv
rtl/ts_apb_regs.sv
rtl/ts_sprite_file.sv
rtl/ts_sprite_scan.sv
rtl/ts_sprite_top.sv
tb/ts_checker.sv
tb/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sprite scanner testbench, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_top -f sources.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
